// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/ex_decode.sv
  - logic/ex_alu.sv
  - logic/ex_csr_calc.sv
  - logic/ex_redirect.sv
  - logic/ex_result_reg.sv
  - logic/ex_stage.sv
  - target: test
    files:
      - verification/tb_ex_stage.sv

// ==== flist.f ====
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_csr_calc.sv
logic/ex_redirect.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
verification/tb_ex_stage.sv

// ==== logic/ex_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::xlen_t   op1_i,
    input  ex_pkg::xlen_t   op2_i,
    input  ex_pkg::alu_op_t alu_op_i,
    output ex_pkg::xlen_t   result_o
);
    import ex_pkg::*;

    logic [5:0] shamt;   // rv64 shift amount
    logic       lt_s;
    logic       lt_u;
    xlen_t      sum;
    xlen_t      diff;
    xlen_t      sll_res;
    xlen_t      srl_res;
    xlen_t      sra_res;

    assign shamt = op2_i[5:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;
    assign sum   = op1_i + op2_i;
    assign diff  = op1_i - op2_i;

    assign sll_res = op1_i << shamt;
    assign srl_res = op1_i >> shamt;
    assign sra_res = xlen_t'($signed(op1_i) >>> shamt); // fills with op1[63]

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_SLL:  result_o = sll_res;
            ALU_SLT:  result_o = {63'b0, lt_s};
            ALU_SLTU: result_o = {63'b0, lt_u};
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SRL:  result_o = srl_res;
            ALU_SRA:  result_o = sra_res;
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            default:  result_o = '0; // codes 10..15 unused
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_csr_calc.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_csr_calc (
    input  ex_pkg::xlen_t   csr_rdata_i,
    input  ex_pkg::xlen_t   op1_i,
    input  ex_pkg::funct3_t funct3_i,
    input  logic [4:0]      uimm_i,
    output ex_pkg::xlen_t   csr_wdata_o
);
    import ex_pkg::*;

    xlen_t src; // rs1 value or zero-extended uimm

    assign src = funct3_i[2] ? {59'b0, uimm_i} : op1_i;

    always_comb begin
        case (funct3_i)
            F3_CSRRW, F3_CSRRWI: csr_wdata_o = src;
            F3_CSRRS, F3_CSRRSI: csr_wdata_o = csr_rdata_i | src;
            F3_CSRRC, F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src;
            default:             csr_wdata_o = csr_rdata_i; // old value kept for non-csr codes
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_decode (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_dec_t dec_o
);
    import ex_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    alt_ok;  // funct3 codes that have an alt form
    logic    sri_alt; // srai marker in the immediate

    function automatic alu_op_t map_alu(input funct3_t f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = req_i.inst[6:0];
    assign funct3  = req_i.inst[14:12];
    assign funct7  = req_i.inst[31:25];
    assign alt_ok  = (funct3 == F3_ADD) || (funct3 == F3_SR);
    // bit 25 is shamt[5] on rv64, so only bit 30 is looked at
    assign sri_alt = (funct3 == F3_SR) && req_i.inst[30];

    always_comb begin
        dec_o            = '0;
        dec_o.csr_funct3 = funct3;
        dec_o.uimm       = req_i.inst[19:15];
        dec_o.alu_op     = ALU_ADD; // link value and auipc use the adder
        case (opcode)
            OPC_OP_IMM: begin
                dec_o.alu_op = map_alu(funct3, sri_alt);
                dec_o.is_alu = 1'b1;
            end
            OPC_OP: begin
                dec_o.alu_op = map_alu(funct3, funct7[5]);
                dec_o.is_alu = (funct7 == F7_BASE) || ((funct7 == F7_ALT) && alt_ok);
            end
            OPC_JAL:    dec_o.is_jump  = 1'b1;
            OPC_JALR:   dec_o.is_jump  = (funct3 == 3'b000);
            OPC_LUI:    dec_o.is_lui   = 1'b1;
            OPC_AUIPC:  dec_o.is_auipc = 1'b1;
            OPC_SYSTEM: dec_o.is_csr   = (funct3[1:0] != 2'b00); // ecall and friends excluded
            default:    ;
        endcase
        dec_o.valid_op = dec_o.is_alu | dec_o.is_jump | dec_o.is_lui |
                         dec_o.is_auipc | dec_o.is_csr;
    end

endmodule

`default_nettype wire

// ==== logic/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef logic [63:0] xlen_t;     // data or address word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t; // csr number only
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [3:0]  alu_op_t;

    // major opcodes handled here
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct3_t F3_ADD  = 3'b000; // also sub
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // srl or sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000; // sub and sra

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // instruction as it leaves the id_ex register
    typedef struct packed {
        inst_t     inst;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     base_addr;   // jump base
        xlen_t     addr_offset;
        reg_addr_t rd_addr;
        logic      rd_wen;
        logic      csr_we;
        csr_addr_t csr_waddr;
        xlen_t     csr_rdata;   // old csr value
    } ex_req_t;

    typedef struct packed {
        logic      rd_wen;
        reg_addr_t rd_addr;
        xlen_t     rd_data;
    } ex_wb_t;

    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        xlen_t     wdata;
    } ex_csr_wr_t;

    typedef struct packed {
        logic  jump_en;
        xlen_t jump_addr;
    } ex_redirect_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       is_alu;
        logic       is_jump;    // jal or jalr
        logic       is_lui;
        logic       is_auipc;
        logic       is_csr;
        funct3_t    csr_funct3;
        logic [4:0] uimm;       // rs1 field of csr immediate forms
        logic       valid_op;   // recognised encoding
    } ex_dec_t;

endpackage

`default_nettype wire

// ==== logic/ex_redirect.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_redirect (
    input  ex_pkg::ex_req_t      req_i,
    input  ex_pkg::ex_dec_t      dec_i,
    input  ex_pkg::xlen_t        alu_result_i,
    input  ex_pkg::xlen_t        csr_wdata_i,
    input  logic                 valid_i,
    input  logic                 int_assert_i,
    input  ex_pkg::xlen_t        int_addr_i,
    output logic                 capture_o,
    output ex_pkg::ex_wb_t       wb_o,
    output ex_pkg::ex_csr_wr_t   csr_wr_o,
    output ex_pkg::ex_redirect_t redirect_o
);
    import ex_pkg::*;

    xlen_t wb_data;
    xlen_t jump_target; // base plus offset for jal and jalr
    logic  rd_wen_raw;
    logic  csr_we_raw;

    always_comb begin
        if (dec_i.is_lui) begin
            wb_data = req_i.op1;         // immediate arrives pre-shifted
        end else if (dec_i.is_csr) begin
            wb_data = req_i.csr_rdata;   // rd gets the old csr value
        end else begin
            wb_data = alu_result_i;      // alu, link value, auipc
        end
    end

    assign jump_target = req_i.base_addr + req_i.addr_offset;

    assign rd_wen_raw = valid_i & dec_i.valid_op & req_i.rd_wen;
    assign csr_we_raw = valid_i & dec_i.is_csr & req_i.csr_we;

    // an interrupt wins over whatever is in the stage
    assign wb_o.rd_wen  = rd_wen_raw & ~int_assert_i;
    assign wb_o.rd_addr = req_i.rd_addr;
    assign wb_o.rd_data = wb_data;

    assign csr_wr_o.we    = csr_we_raw & ~int_assert_i;
    assign csr_wr_o.waddr = req_i.csr_waddr;
    assign csr_wr_o.wdata = csr_wdata_i;

    assign redirect_o.jump_en   = int_assert_i | (valid_i & dec_i.is_jump);
    assign redirect_o.jump_addr = int_assert_i ? int_addr_i : jump_target;

    assign capture_o = valid_i | int_assert_i;

endmodule

`default_nettype wire

// ==== logic/ex_result_reg.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_result_reg (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 capture_i,
    input  ex_pkg::ex_wb_t       wb_i,
    input  ex_pkg::ex_csr_wr_t   csr_wr_i,
    input  ex_pkg::ex_redirect_t redirect_i,
    output logic                 valid_o,
    output ex_pkg::ex_wb_t       wb_o,
    output ex_pkg::ex_csr_wr_t   csr_wr_o,
    output ex_pkg::ex_redirect_t redirect_o
);
    import ex_pkg::*;

    logic      valid_q;
    logic      rd_wen_q;
    logic      csr_we_q;
    logic      jump_en_q;
    reg_addr_t rd_addr_q;
    xlen_t     rd_data_q;
    csr_addr_t csr_waddr_q;
    xlen_t     csr_wdata_q;
    xlen_t     jump_addr_q;

    // enables live for one cycle only
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            rd_wen_q  <= 1'b0;
            csr_we_q  <= 1'b0;
            jump_en_q <= 1'b0;
        end else begin
            valid_q   <= capture_i;
            rd_wen_q  <= capture_i & wb_i.rd_wen;
            csr_we_q  <= capture_i & csr_wr_i.we;
            jump_en_q <= capture_i & redirect_i.jump_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_i) begin  // data holds between results
            rd_addr_q   <= wb_i.rd_addr;
            rd_data_q   <= wb_i.rd_data;
            csr_waddr_q <= csr_wr_i.waddr;
            csr_wdata_q <= csr_wr_i.wdata;
            jump_addr_q <= redirect_i.jump_addr;
        end
    end

    assign valid_o              = valid_q;
    assign wb_o.rd_wen          = rd_wen_q;
    assign wb_o.rd_addr         = rd_addr_q;
    assign wb_o.rd_data         = rd_data_q;
    assign csr_wr_o.we          = csr_we_q;
    assign csr_wr_o.waddr       = csr_waddr_q;
    assign csr_wr_o.wdata       = csr_wdata_q;
    assign redirect_o.jump_en   = jump_en_q;
    assign redirect_o.jump_addr = jump_addr_q;

    // an enable from ex_redirect always comes with a capture
    a_no_en_without_capture: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !capture_i |-> !(wb_i.rd_wen || csr_wr_i.we || redirect_i.jump_en)
    ) else $error("ex_result_reg: enable offered without capture");

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  ex_pkg::ex_req_t      req_i,
    input  logic                 int_assert_i,  // from clint
    input  ex_pkg::xlen_t        int_addr_i,
    output logic                 valid_o,
    output ex_pkg::ex_wb_t       wb_o,
    output ex_pkg::ex_csr_wr_t   csr_wr_o,
    output ex_pkg::ex_redirect_t redirect_o
);
    import ex_pkg::*;

    ex_dec_t      dec;
    xlen_t        alu_result;
    xlen_t        csr_wdata;
    logic         capture;
    ex_wb_t       wb_d;
    ex_csr_wr_t   csr_wr_d;
    ex_redirect_t redirect_d;

    ex_decode u_decode (
        .req_i (req_i),
        .dec_o (dec)
    );

    ex_alu u_alu (
        .op1_i    (req_i.op1),
        .op2_i    (req_i.op2),
        .alu_op_i (dec.alu_op),
        .result_o (alu_result)
    );

    ex_csr_calc u_csr_calc (
        .csr_rdata_i (req_i.csr_rdata),
        .op1_i       (req_i.op1),
        .funct3_i    (dec.csr_funct3),
        .uimm_i      (dec.uimm),
        .csr_wdata_o (csr_wdata)
    );

    ex_redirect u_redirect (
        .req_i        (req_i),
        .dec_i        (dec),
        .alu_result_i (alu_result),
        .csr_wdata_i  (csr_wdata),
        .valid_i      (valid_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .capture_o    (capture),
        .wb_o         (wb_d),
        .csr_wr_o     (csr_wr_d),
        .redirect_o   (redirect_d)
    );

    ex_result_reg u_result_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .capture_i  (capture),
        .wb_i       (wb_d),
        .csr_wr_i   (csr_wr_d),
        .redirect_i (redirect_d),
        .valid_o    (valid_o),
        .wb_o       (wb_o),
        .csr_wr_o   (csr_wr_o),
        .redirect_o (redirect_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_ex_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    typedef struct packed {
        logic      rd_wen;
        reg_addr_t rd_addr;
        logic      chk_data;   // rd_data only matters for a real result
        xlen_t     rd_data;
        logic      csr_we;
        logic      chk_csr;
        csr_addr_t csr_waddr;
        xlen_t     csr_wdata;
        logic      jump_en;
        xlen_t     jump_addr;
    } exp_t;

    logic         clk_i;
    logic         rst_n_i;
    logic         valid_i;
    ex_req_t      req_i;
    logic         int_assert_i;
    xlen_t        int_addr_i;
    logic         valid_o;
    ex_wb_t       wb_o;
    ex_csr_wr_t   csr_wr_o;
    ex_redirect_t redirect_o;

    exp_t   exp_q[$];
    string  name_q[$];
    exp_t   exp_cur;      // result that should be on the outputs now
    string  exp_name;
    logic   exp_valid;
    logic   strobe_seen;
    integer seed;
    integer errors;
    integer results;

    ex_stage dut0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .valid_o      (valid_o),
        .wb_o         (wb_o),
        .csr_wr_o     (csr_wr_o),
        .redirect_o   (redirect_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        strobe_seen <= rst_n_i && (valid_i || int_assert_i);
    end

    // strobe taken at the last rising edge is now on the outputs
    always @(negedge clk_i) begin
        exp_valid = strobe_seen;
        if (strobe_seen) begin
            exp_cur  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            results  = results + 1;
        end
    end

    task automatic report_mismatch(input string field, input xlen_t expected, input xlen_t actual);
        errors = errors + 1;
        $display("FAILED %s %s expected %h actual %h", exp_name, field, expected, actual);
    endtask

    a_valid_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o == exp_valid)
        else begin
            errors = errors + 1;
            $display("valid_o is %b but the strobe one cycle earlier called for %b",
                     $sampled(valid_o), $sampled(exp_valid));
        end
    a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !valid_o |-> !(wb_o.rd_wen || csr_wr_o.we || redirect_o.jump_en))
        else begin
            errors = errors + 1;
            $display("a write or jump enable is high while valid_o is low");
        end
    a_rd_wen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> wb_o.rd_wen == exp_cur.rd_wen)
        else report_mismatch("rd_wen", exp_cur.rd_wen, $sampled(wb_o.rd_wen));
    a_rd_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && exp_cur.rd_wen |-> wb_o.rd_addr == exp_cur.rd_addr)
        else report_mismatch("rd_addr", exp_cur.rd_addr, $sampled(wb_o.rd_addr));
    a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && exp_cur.chk_data |-> wb_o.rd_data == exp_cur.rd_data)
        else report_mismatch("rd_data", exp_cur.rd_data, $sampled(wb_o.rd_data));
    a_csr_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> csr_wr_o.we == exp_cur.csr_we)
        else report_mismatch("csr we", exp_cur.csr_we, $sampled(csr_wr_o.we));
    a_csr_waddr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && exp_cur.csr_we |-> csr_wr_o.waddr == exp_cur.csr_waddr)
        else report_mismatch("csr waddr", exp_cur.csr_waddr, $sampled(csr_wr_o.waddr));
    a_csr_wdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && exp_cur.chk_csr |-> csr_wr_o.wdata == exp_cur.csr_wdata)
        else report_mismatch("csr wdata", exp_cur.csr_wdata, $sampled(csr_wr_o.wdata));
    a_jump_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> redirect_o.jump_en == exp_cur.jump_en)
        else report_mismatch("jump_en", exp_cur.jump_en, $sampled(redirect_o.jump_en));
    a_jump_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && exp_cur.jump_en |-> redirect_o.jump_addr == exp_cur.jump_addr)
        else report_mismatch("jump_addr", exp_cur.jump_addr, $sampled(redirect_o.jump_addr));

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xlen_t alu_result(input alu_op_t op, input xlen_t a, input xlen_t b);
        int unsigned sh;
        xlen_t       res;
        sh = b[5:0];
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + ~b + 64'd1;
            ALU_SLL:  res = a << sh;
            ALU_SLT:  res = (a[63] != b[63]) ? {63'b0, a[63]} : {63'b0, a < b}; // sign decides first
            ALU_SLTU: res = {63'b0, a < b};
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = a >> sh;
            ALU_SRA:  res = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
            ALU_OR:   res = a | b;
            default:  res = a & b;
        endcase
        return res;
    endfunction

    function automatic xlen_t csr_new_value(input funct3_t f3, input xlen_t old,
                                            input xlen_t rs1, input logic [4:0] uimm);
        xlen_t src;
        xlen_t res;
        src = (f3 == F3_CSRRWI || f3 == F3_CSRRSI || f3 == F3_CSRRCI) ? xlen_t'(uimm) : rs1;
        case (f3)
            F3_CSRRW, F3_CSRRWI: res = src;
            F3_CSRRS, F3_CSRRSI: res = old | src;
            default:             res = old & ~src;
        endcase
        return res;
    endfunction

    function automatic ex_req_t random_req(input funct7_t f7, input funct3_t f3, input opcode_t opc);
        ex_req_t     r;
        logic [31:0] bits;
        bits          = $random(seed);
        r.inst        = {f7, bits[9:0], f3, bits[14:10], opc};
        r.op1         = rand64();
        r.op2         = rand64();
        r.base_addr   = rand64();
        r.addr_offset = rand64();
        r.rd_addr     = bits[19:15];
        r.rd_wen      = 1'b1;
        r.csr_we      = bits[20];
        r.csr_waddr   = bits[31:20];
        r.csr_rdata   = rand64();
        return r;
    endfunction

    task automatic drive_strobe(input logic v, input logic irq, input ex_req_t r,
                                input xlen_t irq_addr, input exp_t e, input string name);
        @(negedge clk_i);
        valid_i      = v;
        int_assert_i = irq;
        req_i        = r;
        int_addr_i   = irq_addr;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            valid_i      = 1'b0;
            int_assert_i = 1'b0;
        end
    endtask

    task automatic run_alu_tests();
        funct3_t f3_of [10] = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU,
                                F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
        ex_req_t r;
        exp_t    e;
        logic    alt;
        for (int i = 0; i < 10; i++) begin
            alt = (alu_op_t'(i) == ALU_SUB) || (alu_op_t'(i) == ALU_SRA);
            for (int k = 0; k < 6; k++) begin
                // odd passes use op-imm, which has no sub form
                r = random_req(alt ? F7_ALT : F7_BASE, f3_of[i],
                               (k[0] && alu_op_t'(i) != ALU_SUB) ? OPC_OP_IMM : OPC_OP);
                if (k < 2) begin
                    r.op1[63] = 1'b1;  // negative operand
                end
                e          = '0;
                e.rd_wen   = 1'b1;
                e.rd_addr  = r.rd_addr;
                e.chk_data = 1'b1;
                e.rd_data  = alu_result(alu_op_t'(i), r.op1, r.op2);
                drive_strobe(1'b1, 1'b0, r, rand64(), e, $sformatf("alu_op_%0d", i));
            end
        end
        r = random_req(7'b0000001, F3_ADD, OPC_OP);  // mul encoding
        drive_strobe(1'b1, 1'b0, r, rand64(), '0, "alu_bad_funct7");
    endtask

    task automatic run_flow_tests();
        ex_req_t r;
        exp_t    e;
        for (int k = 0; k < 8; k++) begin
            r = random_req(F7_BASE, F3_ADD, k[0] ? OPC_JALR : OPC_JAL);
            if (k >= 4) begin
                r.inst[6:0] = k[0] ? OPC_AUIPC : OPC_LUI;
            end
            e           = '0;
            e.rd_wen    = 1'b1;
            e.rd_addr   = r.rd_addr;
            e.chk_data  = 1'b1;
            e.rd_data   = (k >= 4 && !k[0]) ? r.op1 : r.op1 + r.op2;
            e.jump_en   = (k < 4);
            e.jump_addr = r.base_addr + r.addr_offset;
            drive_strobe(1'b1, 1'b0, r, rand64(), e, (k < 4) ? "jump" : "upper_imm");
        end
        r = random_req(F7_BASE, F3_ADD, 7'b0000011);  // load opcode is not handled here
        drive_strobe(1'b1, 1'b0, r, rand64(), '0, "unknown_opcode");
    endtask

    task automatic run_csr_tests();
        funct3_t csr_ops [6] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        ex_req_t r;
        exp_t    e;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                r           = random_req(7'($random(seed)), csr_ops[i], OPC_SYSTEM);
                e           = '0;
                e.rd_wen    = 1'b1;
                e.rd_addr   = r.rd_addr;
                e.chk_data  = 1'b1;
                e.rd_data   = r.csr_rdata;
                e.csr_we    = r.csr_we;
                e.chk_csr   = 1'b1;
                e.csr_waddr = r.csr_waddr;
                e.csr_wdata = csr_new_value(csr_ops[i], r.csr_rdata, r.op1, r.inst[19:15]);
                drive_strobe(1'b1, 1'b0, r, rand64(), e, $sformatf("csr_f3_%0d", csr_ops[i]));
            end
        end
    endtask

    task automatic run_irq_tests();
        ex_req_t r;
        exp_t    e;
        for (int k = 0; k < 6; k++) begin
            r           = random_req(F7_BASE, k[1] ? F3_CSRRS : F3_ADD, k[1] ? OPC_SYSTEM : OPC_JAL);
            r.csr_we    = 1'b1;
            e           = '0;
            e.jump_en   = 1'b1;
            e.jump_addr = rand64();
            drive_strobe(k[0], 1'b1, r, e.jump_addr, e, k[0] ? "irq_with_valid" : "irq_alone");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || exp_valid) && n < 20) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0 || exp_valid) begin
            errors = errors + 1;
            $display("timeout: results still outstanding after 20 cycles");
        end
        @(negedge clk_i);  // lets the last valid_o low check run
    endtask

    initial begin
        seed         = 66272;
        errors       = 0;
        results      = 0;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        req_i        = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        exp_cur      = '0;
        exp_name     = "";
        exp_valid    = 1'b0;
        strobe_seen  = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        drive_idle(3);  // nothing may come out before the first strobe
        run_alu_tests();
        drive_idle(2);
        run_flow_tests();
        drive_idle(1);
        run_csr_tests();
        run_irq_tests();
        drive_idle(1);
        wait_drain();
        $display("results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
